// ==== project.f ====
+incdir+verilog
+incdir+testbench
verilog/npu_mem_pkg.sv
verilog/npu_win_pkg.sv
verilog/window_loader.sv
verilog/lane_scratchpad.sv
verilog/window_reader.sv
verilog/npu_feeder.sv
testbench/tb_npu_feeder.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the feeder testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --assert -Wno-fatal \
	--top-module tb_npu_feeder \
	-f project.f \
	--Mdir obj_dir -o tb_npu_feeder

./obj_dir/tb_npu_feeder > sim.log 2>&1

if grep -q "^Finished with no errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== testbench/tb_feeder_checks.svh ====
`ifndef TB_FEEDER_CHECKS_SVH
`define TB_FEEDER_CHECKS_SVH

// shadow of the scratchpad regions the DUT uses
mem_word_u shadow_pix [`NPU_FMAP_H][`NPU_FMAP_W];	// same byte in every lane slot
mem_word_u shadow_w [`NPU_MEM_H];	// weight row per channel
mem_word_u shadow_b [`NPU_MEM_H];	// only the top 16 bits matter
int m_bias = 0;	// placement counters, mirror of the loader
int m_weight = 0;
int m_pcol = 0;
int m_prow = 0;

// placement rules: bias and weight rows count up, pixels in raster order
function automatic void model_load(load_kind_t kind, mem_word_u word);
	case (kind)
		kind_bias: begin
			shadow_b[m_bias] = word;
			m_bias = (m_bias + 1) % `NPU_MEM_H;
		end
		kind_weight: begin
			shadow_w[m_weight] = word;
			m_weight = (m_weight + 1) % `NPU_MEM_H;
		end
		default: begin
			shadow_pix[m_prow][m_pcol] = word;
			m_pcol = m_pcol + 1;	// column first
			if (m_pcol == `NPU_FMAP_W) begin
				m_pcol = 0;
				m_prow = (m_prow + 1) % `NPU_FMAP_H;	// wraps to (0,0)
			end
		end
	endcase
endfunction

// window idx in pool order: quadrant fastest, then column pair, then row pair
function automatic window_t exp_window(int idx);
	window_t w;
	int l;
	int cc;
	int cr;
	int nc;
	int nr;
	l = idx % 4;
	cc = 2 * ((idx / 4) % (`NPU_FMAP_W / 2)) + l / 2;
	cr = 2 * (idx / (2 * `NPU_FMAP_W)) + l % 2;
	w = '0;	// padded lanes stay zero
	w.valid = 1'b1;
	w.quad = 2'(l);
	w.col = col_addr_t'(cc);
	w.row = row_addr_t'(cr);
	for (int n = 0; n < `NPU_LANES; n++) begin
		nc = cc + n % 3 - 1;
		nr = cr + n / 3 - 1;
		if (nc >= 0 && nc < `NPU_FMAP_W && nr >= 0 && nr < `NPU_FMAP_H) begin
			w.mask[`NPU_LANES-1-n] = 1'b1;	// bit 8 is lane 0
			w.pixels[n] = shadow_pix[nr][nc].lanes[n];
		end
	end
	return w;
endfunction

function automatic coef_t exp_coef(row_addr_t c);
	coef_t e;
	e.valid = 1'b1;
	e.weights = shadow_w[c].lanes;	// signed view of the same bytes
	e.bias = shadow_b[c].bias.value;
	return e;
endfunction

task automatic check_window(string name, window_t exp, window_t act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("Mismatch %s: expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_coef(string name, coef_t exp, coef_t act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("Mismatch %s: expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_flag(string name, logic exp, logic act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("Mismatch %s: expected %b actual %b", name, exp, act);
	end
endtask

`endif

// ==== testbench/tb_npu_feeder.sv ====
`timescale 1ns/1ns
`include "npu_cfg.svh"

module tb_npu_feeder
	import npu_mem_pkg::*, npu_win_pkg::*;
();

	localparam int win_n = `NPU_FMAP_W * `NPU_FMAP_H;	// windows per pass
	localparam int max_loads = 2 * `NPU_MEM_H + 2 * win_n;	// reload at most win_n - 1
	localparam int cycle_limit = max_loads + 2 * (win_n + 4) + 100;

	logic clk;
	logic rst_n;
	load_req_t load;
	logic start;
	row_addr_t ch;
	logic busy;
	window_t window;
	coef_t coef;
	logic done;

	int check_count = 0;
	int err_count = 0;
	int chk_mark = 0;	// counts at the start of the current test
	int err_mark = 0;
	int test_count = 0;

	`include "tb_feeder_checks.svh"

	npu_feeder i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.start(start),
		.ch(ch),
		.busy(busy),
		.window(window),
		.coef(coef),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic mem_word_u random_word();
		logic [95:0] r;
		r[31:0] = $urandom;
		r[63:32] = $urandom;
		r[95:64] = $urandom;
		return mem_word_u'(r[71:0]);
	endfunction

	task automatic finish_test(string name);
		$display("test %s finished: %0d checks, %0d errors", name,
			check_count - chk_mark, err_count - err_mark);
		chk_mark = check_count;
		err_mark = err_count;
		test_count++;
	endtask

	// one load beat per falling edge, shadow follows
	task automatic drive_load(load_kind_t kind);
		mem_word_u word;
		word = random_word();
		@(negedge clk);
		load.valid = 1'b1;
		load.kind = kind;
		load.word = word;
		model_load(kind, word);
	endtask

	// start one pass and follow it cycle by cycle until done
	task automatic run_pass(string name, row_addr_t c);
		int cyc;
		int seen;
		logic fin;
		coef_t ec;
		ec = exp_coef(c);
		cyc = 0;
		seen = 0;
		fin = 1'b0;
		@(negedge clk);
		load = '0;	// loads stop before the pass
		start = 1'b1;
		ch = c;
		while (!fin) begin
			@(negedge clk);
			start = 1'b0;
			cyc++;
			check_flag($sformatf("%s busy cycle %0d", name, cyc), cyc < win_n + 3, busy);
			if (cyc == 3)	// two cycles after the accept edge
				check_coef($sformatf("%s coef", name), ec, coef);
			else
				check_flag($sformatf("%s coef.valid cycle %0d", name, cyc), 1'b0, coef.valid);
			if (cyc >= 4 && cyc < 4 + win_n)	// back to back windows
				check_window($sformatf("%s window %0d", name, cyc - 4),
					exp_window(cyc - 4), window);
			else
				check_flag($sformatf("%s window.valid cycle %0d", name, cyc), 1'b0,
					window.valid);
			if (window.valid) seen++;
			check_flag($sformatf("%s done cycle %0d", name, cyc), cyc == win_n + 3, done);
			fin = done;	// timeout guards a missing done
		end
		if (seen != win_n) begin
			err_count++;
			$display("Mismatch %s window count: expected %0d actual %0d", name, win_n, seen);
		end
		finish_test(name);
	endtask

	initial begin
		int n_reload;
		row_addr_t c;
		void'($urandom(88843));
		rst_n = 1'b0;
		load = '0;
		start = 1'b0;
		ch = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (3) begin	// quiet outputs after reset
			@(negedge clk);
			check_flag("reset_idle busy", 1'b0, busy);
			check_flag("reset_idle done", 1'b0, done);
			check_flag("reset_idle coef.valid", 1'b0, coef.valid);
			check_flag("reset_idle window.valid", 1'b0, window.valid);
		end
		finish_test("reset_idle");
		for (int i = 0; i < `NPU_MEM_H; i++) drive_load(kind_bias);
		for (int i = 0; i < `NPU_MEM_H; i++) drive_load(kind_weight);
		for (int i = 0; i < win_n; i++) drive_load(kind_pixel);
		c = row_addr_t'($urandom % `NPU_MEM_H);
		run_pass("pass1", c);
		n_reload = 1 + $urandom % (win_n - 1);	// partial overwrite from (0,0)
		$display("reloading %0d pixels", n_reload);
		for (int i = 0; i < n_reload; i++) drive_load(kind_pixel);
		c = row_addr_t'($urandom % `NPU_MEM_H);
		run_pass("pass2_reload", c);
		$display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			err_count);
		if (err_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// run limit from the load count and two full passes
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles waiting for done", cycles);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== verilog/lane_scratchpad.sv ====
`timescale 1ns/1ns
`include "npu_cfg.svh"

module lane_scratchpad
	import npu_mem_pkg::*;
(
	input logic clk,
	input wr_cmd_t wr,
	input rd_cmd_t rd,
	output mem_word_u rd_word
);

	// nine byte arrays, one per window lane
	lane_byte_t mem [`NPU_LANES][`NPU_MEM_H][`NPU_MEM_W];

	// shared write address, private read address per lane
	always_ff @(posedge clk) begin
		for (int n = 0; n < `NPU_LANES; n++) begin
			if (wr.en && wr.mask[`NPU_LANES-1-n]) begin
				mem[n][wr.row][wr.col] <= wr.word.lanes[n];	// lane n byte
			end
			// registered read, old data on a same-cell write
			rd_word.lanes[n] <= mem[n][rd.row[n]][rd.col[n]];
		end
	end

	// enabled lanes must stay inside the array
	for (genvar n = 0; n < `NPU_LANES; n++) begin : g_rd_chk
		a_rd_in_range: assert property (@(posedge clk)
			rd.mask[`NPU_LANES-1-n] |->
				(rd.col[n] < `NPU_MEM_W) && (rd.row[n] < `NPU_MEM_H))
			else $error("lane_scratchpad: lane %0d read (%0d,%0d) out of range",
				n, rd.col[n], rd.row[n]);
	end

endmodule

// ==== verilog/npu_cfg.svh ====
`ifndef NPU_CFG_SVH
`define NPU_CFG_SVH

// window size, one lane per 3x3 neighbour
`define NPU_LANES 9

// scratchpad geometry
`define NPU_MEM_W 80	// columns per lane array
`define NPU_MEM_H 8	// rows, also output channel count

// feature map walked by the reader, both sides even
`define NPU_FMAP_W 8
`define NPU_FMAP_H 8	// no more than NPU_MEM_H

// reserved columns at the right edge of the scratchpad
`define NPU_WEIGHT_COL (`NPU_MEM_W - 9)	// one weight row per channel
`define NPU_BIAS_COL (`NPU_MEM_W - 1)	// bias in lanes 0 and 1

// address widths
`define NPU_COL_BITS 7
`define NPU_ROW_BITS 3

`endif

// ==== verilog/npu_feeder.sv ====
`timescale 1ns/1ns

module npu_feeder
	import npu_mem_pkg::*, npu_win_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input load_req_t load,
	input logic start,
	input row_addr_t ch,	// coefficient row
	output logic busy,
	output window_t window,
	output coef_t coef,
	output logic done
);

	wr_cmd_t wr;	// loader to scratchpad
	rd_cmd_t rd;	// reader to scratchpad
	mem_word_u rd_word;	// registered read data

	window_loader i_loader (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.wr(wr)
	);

	lane_scratchpad i_mem (
		.clk(clk),
		.wr(wr),
		.rd(rd),
		.rd_word(rd_word)
	);

	window_reader i_reader (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.ch(ch),
		.rd_word(rd_word),
		.rd(rd),
		.busy(busy),
		.window(window),
		.coef(coef),
		.done(done)
	);

	// the scratchpad is not double-buffered
	a_no_load_busy: assert property (@(posedge clk) disable iff (!rst_n)
		load.valid |-> !busy)
		else $error("npu_feeder: load kind %0d during a pass", load.kind);

endmodule

// ==== verilog/npu_mem_pkg.sv ====
`include "npu_cfg.svh"

package npu_mem_pkg;

	typedef logic [7:0] lane_byte_t;	// one lane datum
	typedef logic [`NPU_COL_BITS-1:0] col_addr_t;
	typedef logic [`NPU_ROW_BITS-1:0] row_addr_t;
	typedef logic [`NPU_LANES-1:0] lane_mask_t;	// bit 8 is lane 0, top-left
	typedef logic signed [15:0] bias_t;

	// lanes 0 and 1 carry the bias word
	localparam lane_mask_t bias_lanes = {2'b11, {(`NPU_LANES - 2){1'b0}}};

	typedef struct packed {
		bias_t value;	// top two lane bytes
		logic [8*(`NPU_LANES-2)-1:0] pad;	// lanes 2..8, unused
	} bias_view_t;

	// one scratchpad word, read as lane bytes or as a bias
	typedef union packed {
		lane_byte_t [0:`NPU_LANES-1] lanes;	// lane 0 in the top byte
		bias_view_t bias;
	} mem_word_u;

	// shared write port, one cell address for all lanes
	typedef struct packed {
		logic en;
		col_addr_t col;
		row_addr_t row;
		lane_mask_t mask;	// lanes actually written
		mem_word_u word;
	} wr_cmd_t;

	// one address pair per lane
	typedef struct packed {
		col_addr_t [0:`NPU_LANES-1] col;
		row_addr_t [0:`NPU_LANES-1] row;
		lane_mask_t mask;	// enabled lanes, others held at 0
	} rd_cmd_t;

endpackage

// ==== verilog/npu_win_pkg.sv ====
`include "npu_cfg.svh"

package npu_win_pkg;

	import npu_mem_pkg::*;

	typedef enum logic [1:0] {
		kind_bias = 2'd0,
		kind_weight = 2'd1,
		kind_pixel = 2'd2
	} load_kind_t;	// 2'd3 is illegal

	typedef logic signed [7:0] weight_t;

	// one load beat, no handshake
	typedef struct packed {
		logic valid;
		load_kind_t kind;
		mem_word_u word;
	} load_req_t;

	// one 3x3 window per output position
	typedef struct packed {
		logic valid;
		logic [1:0] quad;	// max-pool quadrant l
		col_addr_t col;	// centre column
		row_addr_t row;	// centre row
		lane_mask_t mask;	// 0 = padded neighbour
		lane_byte_t [0:`NPU_LANES-1] pixels;	// padded lanes read 0
	} window_t;

	// coefficients of the selected channel
	typedef struct packed {
		logic valid;
		weight_t [0:`NPU_LANES-1] weights;	// lane 0 is top-left tap
		bias_t bias;
	} coef_t;

endpackage

// ==== verilog/window_loader.sv ====
`timescale 1ns/1ns
`include "npu_cfg.svh"

module window_loader
	import npu_mem_pkg::*, npu_win_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input load_req_t load,
	output wr_cmd_t wr
);

	localparam col_addr_t last_col = col_addr_t'(`NPU_FMAP_W - 1);
	localparam row_addr_t last_row = row_addr_t'(`NPU_FMAP_H - 1);
	localparam row_addr_t last_ch = row_addr_t'(`NPU_MEM_H - 1);

	row_addr_t bias_row;	// next bias slot
	row_addr_t weight_row;	// next weight slot
	col_addr_t pix_col;	// raster pointer, column first
	row_addr_t pix_row;

	// placement by kind, write goes out in the load cycle
	always_comb begin
		wr.en = load.valid;
		wr.word = load.word;	// payload passes as is
		case (load.kind)
			kind_bias: begin
				wr.col = col_addr_t'(`NPU_BIAS_COL);
				wr.row = bias_row;
				wr.mask = bias_lanes;	// lanes 0 and 1 only
			end
			kind_weight: begin
				wr.col = col_addr_t'(`NPU_WEIGHT_COL);
				wr.row = weight_row;
				wr.mask = '1;
			end
			kind_pixel: begin
				wr.col = pix_col;
				wr.row = pix_row;
				wr.mask = '1;
			end
			default: begin
				wr.col = '0;
				wr.row = '0;
				wr.mask = '0;	// bad kind writes nothing
			end
		endcase
	end

	// three independent wrapping counters
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bias_row <= '0;
			weight_row <= '0;
			pix_col <= '0;
			pix_row <= '0;
		end else if (load.valid) begin
			case (load.kind)
				kind_bias: bias_row <= (bias_row == last_ch) ? '0 : bias_row + 1'b1;
				kind_weight: weight_row <= (weight_row == last_ch) ? '0 : weight_row + 1'b1;
				kind_pixel: begin
					if (pix_col == last_col) begin
						pix_col <= '0;	// end of line
						pix_row <= (pix_row == last_row) ? '0 : pix_row + 1'b1;
					end else begin
						pix_col <= pix_col + 1'b1;
					end
				end
				default: ;	// counters hold
			endcase
		end
	end

	a_kind_legal: assert property (@(posedge clk) disable iff (!rst_n)
		load.valid |-> load.kind inside {kind_bias, kind_weight, kind_pixel})
		else $error("window_loader: illegal load kind %0d", load.kind);

endmodule

// ==== verilog/window_reader.sv ====
`timescale 1ns/1ns
`include "npu_cfg.svh"

module window_reader
	import npu_mem_pkg::*, npu_win_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input row_addr_t ch,
	input mem_word_u rd_word,
	output rd_cmd_t rd,
	output logic busy,
	output window_t window,
	output coef_t coef,
	output logic done
);

	localparam col_addr_t last_k = col_addr_t'(`NPU_FMAP_W - 2);
	localparam row_addr_t last_j = row_addr_t'(`NPU_FMAP_H - 2);

	typedef enum logic [1:0] {
		ph_idle,
		ph_weight,	// weight row read
		ph_bias,	// bias row read
		ph_sweep	// one window read per cycle
	} phase_t;

	phase_t phase;
	row_addr_t ch_q;	// channel held for the pass
	row_addr_t j;	// row pair
	col_addr_t k;	// column pair
	logic [1:0] l;	// pool quadrant
	col_addr_t cen_col;
	row_addr_t cen_row;
	lane_mask_t win_mask;
	logic sweep_last;

	logic weight_ret;	// rd_word holds the weight row
	logic bias_ret;	// rd_word holds the bias row
	weight_t [0:`NPU_LANES-1] coef_w;

	logic win_v;	// window read returns this cycle
	logic win_last;
	logic [1:0] win_quad;
	col_addr_t win_col;
	row_addr_t win_row;
	lane_mask_t win_mask_q;

	assign busy = (phase != ph_idle);
	assign sweep_last = (phase == ph_sweep) && (l == 2'd3) && (k == last_k) && (j == last_j);

	// quadrant l: column from l[1], row from l[0]
	assign cen_col = k + col_addr_t'(l[1]);
	assign cen_row = j + row_addr_t'(l[0]);

	// read address per phase, padding from fmap bounds
	always_comb begin
		int nc;
		int nr;
		win_mask = '0;
		rd = '0;
		for (int n = 0; n < `NPU_LANES; n++) begin
			nc = int'(cen_col) + (n % 3) - 1;	// raster dc
			nr = int'(cen_row) + (n / 3) - 1;	// raster dr
			win_mask[`NPU_LANES-1-n] = (nc >= 0) && (nc < `NPU_FMAP_W) &&
				(nr >= 0) && (nr < `NPU_FMAP_H);
			if (phase == ph_sweep && win_mask[`NPU_LANES-1-n]) begin
				rd.col[n] = col_addr_t'(nc);
				rd.row[n] = row_addr_t'(nr);	// padded lanes keep 0
			end
		end
		case (phase)
			ph_weight: begin
				rd.col = {`NPU_LANES{col_addr_t'(`NPU_WEIGHT_COL)}};
				rd.row = {`NPU_LANES{ch_q}};
				rd.mask = '1;
			end
			ph_bias: begin
				rd.col[0] = col_addr_t'(`NPU_BIAS_COL);
				rd.col[1] = col_addr_t'(`NPU_BIAS_COL);
				rd.row[0] = ch_q;
				rd.row[1] = ch_q;
				rd.mask = bias_lanes;
			end
			ph_sweep: rd.mask = win_mask;
			default: rd.mask = '0;	// idle, nothing read
		endcase
	end

	// phase FSM and traversal, l fastest, then k, then j
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= ph_idle;
			j <= '0;
			k <= '0;
			l <= '0;
		end else begin
			case (phase)
				ph_idle: begin
					j <= '0;
					k <= '0;
					l <= '0;
					if (start) phase <= ph_weight;
				end
				ph_weight: phase <= ph_bias;
				ph_bias: phase <= ph_sweep;
				default: begin
					l <= l + 1'b1;
					if (l == 2'd3) begin
						if (k == last_k) begin
							k <= '0;
							j <= j + 2'd2;	// next row pair
							if (j == last_j) phase <= ph_idle;
						end else begin
							k <= k + 2'd2;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == ph_idle && start) ch_q <= ch;	// latch on accept
		if (weight_ret) coef_w <= rd_word.lanes;	// weight view
		win_quad <= l;
		win_col <= cen_col;
		win_row <= cen_row;
		win_mask_q <= win_mask;
	end

	// read latency tracking, one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			weight_ret <= 1'b0;
			bias_ret <= 1'b0;
			win_v <= 1'b0;
			win_last <= 1'b0;
		end else begin
			weight_ret <= (phase == ph_weight);
			bias_ret <= (phase == ph_bias);
			win_v <= (phase == ph_sweep);
			win_last <= sweep_last;
		end
	end

	// coef goes out with the bias data
	assign coef.valid = bias_ret;
	assign coef.weights = coef_w;
	assign coef.bias = rd_word.bias.value;	// bias view

	always_comb begin
		window.valid = win_v;
		window.quad = win_quad;
		window.col = win_col;
		window.row = win_row;
		window.mask = win_mask_q;
		for (int n = 0; n < `NPU_LANES; n++) begin
			window.pixels[n] = win_mask_q[`NPU_LANES-1-n] ? rd_word.lanes[n] : '0;	// zero pad
		end
	end

	assign done = win_last;	// busy already low here

	// no new start while a pass runs
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy)
		else $error("window_reader: start raised during a pass");

	// done marks the bottom-right window of the last quadrant
	a_done_win: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> window.valid && (window.quad == 2'd3) &&
			(window.col == col_addr_t'(`NPU_FMAP_W - 1)) &&
			(window.row == row_addr_t'(`NPU_FMAP_H - 1)))
		else $error("window_reader: done without the last window");

endmodule
